// ==== hdl/BvhPkg.sv ====
// BVH package with primitive index widths, lane count, queue depth and group types
package BvhPkg;

    // ------------------------------------------------------------------------
    // Primitive addressing
    // ------------------------------------------------------------------------
    localparam int PrimIndexWidth = 12;
    localparam int PrimCountWidth = 8;

    // Lanes tested by the ray unit in one batch
    localparam int LaneCountLog = 2;
    localparam int LaneCount    = 1 << LaneCountLog;

    // Candidate group queue
    localparam int QueueDepth    = 16;
    localparam int QueuePtrWidth = $clog2(QueueDepth);

    // One contiguous range of primitives that may be hit
    typedef struct packed {
        logic [PrimIndexWidth-1:0] start;
        logic [PrimCountWidth-1:0] count;
    } primGroupT;

    // Two leaf results per cycle from traversal, count of zero means no leaf
    typedef struct packed {
        primGroupT [1:0] leaf;
    } leafBundleT;

    // Per-lane hit flags from the ray unit
    typedef logic [LaneCount-1:0] laneMaskT;

endpackage

// ==== hdl/FragmentPkg.sv ====
// Fragment package with surface types, fragment and result records, FSM states and config map
package FragmentPkg;

    localparam int RayTagWidth  = 16;
    localparam int CfgAddrWidth = 2;
    localparam int CfgDataWidth = 16;

    typedef enum logic [1:0] {
        SurfNone,
        SurfDiffuse,
        SurfSpecular,
        SurfLight
    } surfaceT;

    // Shaded fragment as delivered by the previous stage
    typedef struct packed {
        logic [9:0]             pixelX;
        logic [9:0]             pixelY;
        logic [23:0]            color;
        surfaceT                surface;
        logic [RayTagWidth-1:0] rayTag;
    } fragmentT;

    typedef struct packed {
        fragmentT frag;
        logic     inShadow;
    } shadowResultT;

    typedef enum logic [1:0] {
        ShdwInit,
        ShdwAnyHit,
        ShdwDone
    } shadowStateT;

    // ------------------------------------------------------------------------
    // Configuration register map
    // ------------------------------------------------------------------------
    localparam logic [CfgAddrWidth-1:0] CfgAddrEnable      = 2'd0;
    localparam logic [CfgAddrWidth-1:0] CfgAddrGlobalStart = 2'd1;
    localparam logic [CfgAddrWidth-1:0] CfgAddrGlobalCount = 2'd2;

endpackage

// ==== hdl/ShadowConfig.sv ====
// Shadow configuration registers holding the enable bit and the global primitive group
`timescale 1ns/1ps

module ShadowConfig
    import BvhPkg::*, FragmentPkg::*;
(
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    cfgWrite,
    input  logic [CfgAddrWidth-1:0] cfgAddr,
    input  logic [CfgDataWidth-1:0] cfgData,
    output logic                    shadowEnable,
    output primGroupT               globalGroup
);

    // ------------------------------------------------------------------------
    // Register file
    // ------------------------------------------------------------------------
    // Shadowing comes up enabled with an empty global group
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            shadowEnable <= 1'b1;
            globalGroup  <= '0;
        end else if (cfgWrite) begin
            case (cfgAddr)
                CfgAddrEnable: begin
                    shadowEnable <= cfgData[0];
                end
                CfgAddrGlobalStart: begin
                    globalGroup.start <= cfgData[PrimIndexWidth-1:0];
                end
                CfgAddrGlobalCount: begin
                    // Size zero disables the global group
                    globalGroup.count <= cfgData[PrimCountWidth-1:0];
                end
                default: begin
                    // Unmapped address, write ignored
                    shadowEnable <= shadowEnable;
                end
            endcase
        end
    end

endmodule

// ==== hdl/PrimitiveGroupQueue.sv ====
// Circular FIFO of candidate primitive groups with two writes and one read per cycle
`timescale 1ns/1ps

module PrimitiveGroupQueue
    import BvhPkg::*;
(
    input  logic       clk,
    input  logic       resetn,
    input  logic       clear,
    input  logic       pushGlobal,
    input  primGroupT  globalGroup,
    input  logic       pushLeaves,
    input  leafBundleT leaves,
    input  logic       pop,
    output primGroupT  popGroup,
    output logic       empty
);

    primGroupT mem [QueueDepth];

    logic [QueuePtrWidth-1:0] top;
    logic [QueuePtrWidth-1:0] bottom;
    logic [QueuePtrWidth-1:0] base;
    logic [QueuePtrWidth-1:0] nextSlot;

    primGroupT firstGroup;
    logic      firstOk;
    logic      secondOk;
    primGroupT wrGroup0;
    logic      wr0;
    logic      wr1;

    // ------------------------------------------------------------------------
    // Write compaction
    // ------------------------------------------------------------------------
    // Global group is pushed in Init and leaves in AnyHit, never together
    always_comb begin
        base       = clear ? '0 : bottom;
        nextSlot   = base + 1'b1;
        firstGroup = pushGlobal ? globalGroup : leaves.leaf[0];
        firstOk    = pushGlobal ? (globalGroup.count != '0)
                                : (pushLeaves && (leaves.leaf[0].count != '0));
        secondOk   = !pushGlobal && pushLeaves && (leaves.leaf[1].count != '0);
        // Empty first slot lets the second leaf move down
        wrGroup0   = firstOk ? firstGroup : leaves.leaf[1];
        wr0        = firstOk || secondOk;
        wr1        = firstOk && secondOk;
    end

    always_ff @(posedge clk) begin
        if (wr0) begin
            mem[base] <= wrGroup0;
        end
        if (wr1) begin
            mem[nextSlot] <= leaves.leaf[1];
        end
    end

    // Pointers
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            top    <= '0;
            bottom <= '0;
        end else begin
            bottom <= base + QueuePtrWidth'(wr0) + QueuePtrWidth'(wr1);
            if (clear) begin
                top <= '0;
            end else if (pop && !empty) begin
                top <= top + 1'b1;
            end
        end
    end

    assign popGroup = mem[top];
    assign empty    = (top == bottom);

endmodule

// ==== hdl/BatchStepper.sv ====
// Batch stepper that pads a primitive group to whole lane batches and masks padded lanes
`timescale 1ns/1ps

module BatchStepper
    import BvhPkg::*;
(
    input  logic                      clk,
    input  logic                      resetn,
    input  logic                      clear,
    input  logic                      load,
    input  logic                      step,
    input  primGroupT                 group,
    input  laneMaskT                  laneHits,
    output logic [PrimIndexWidth-1:0] startPrimitive,
    output logic [PrimIndexWidth-1:0] endPrimitive,
    output logic                      batchLeft,
    output logic                      batchHit
);

    logic [PrimIndexWidth-1:0] startIdx;
    logic [PrimIndexWidth-1:0] realEnd;
    logic [PrimIndexWidth-1:0] alignedEnd;
    logic [PrimIndexWidth-1:0] remaining;
    logic [PrimCountWidth:0]   paddedCount;
    logic [PrimCountWidth:0]   roundedCount;
    laneMaskT                  laneValid;

    // ------------------------------------------------------------------------
    // Round the group size up to a multiple of LaneCount
    // ------------------------------------------------------------------------
    assign paddedCount  = {1'b0, group.count} + (PrimCountWidth + 1)'(LaneCount - 1);
    assign roundedCount = {paddedCount[PrimCountWidth:LaneCountLog], {LaneCountLog{1'b0}}};

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            startIdx   <= '0;
            realEnd    <= '0;
            alignedEnd <= '0;
        end else if (clear) begin
            startIdx   <= '0;
            realEnd    <= '0;
            alignedEnd <= '0;
        end else if (load) begin
            startIdx   <= group.start;
            realEnd    <= group.start + PrimIndexWidth'(group.count);
            alignedEnd <= group.start + PrimIndexWidth'(roundedCount);
        end else if (step) begin
            startIdx <= startIdx + PrimIndexWidth'(LaneCount);
        end
    end

    // Lane masking, measured from the batch start so it survives index wrap
    always_comb begin
        remaining = realEnd - startIdx;
        for (int i = 0; i < LaneCount; i++) begin
            laneValid[i] = (remaining > PrimIndexWidth'(i));
        end
    end

    assign batchLeft = (startIdx != alignedEnd);
    assign batchHit  = batchLeft && |(laneHits & laneValid);

    assign startPrimitive = startIdx;
    assign endPrimitive   = realEnd;

endmodule

// ==== hdl/ShadowControl.sv ====
// Shadow controller with input slot, Init/AnyHit/Done FSM and registered result
`timescale 1ns/1ps

module ShadowControl
    import BvhPkg::*, FragmentPkg::*;
(
    input  logic                   clk,
    input  logic                   resetn,
    // Fragment input and result output
    input  logic                   addInput,
    input  fragmentT               fragIn,
    output logic                   fifoFull,
    input  logic                   outputFifoFull,
    output logic                   valid,
    output shadowResultT           result,
    // Configuration
    input  logic                   shadowEnable,
    input  primGroupT              globalGroup,
    // Traversal
    output logic                   travStart,
    output logic                   travRestart,
    output logic [RayTagWidth-1:0] travRay,
    input  logic                   travFinished,
    // Queue and stepper
    output logic                   queueClear,
    output logic                   pushGlobal,
    output logic                   pushLeaves,
    output logic                   pop,
    output logic                   stepClear,
    output logic                   step,
    input  logic                   empty,
    input  primGroupT              popGroup,
    input  logic                   batchLeft,
    input  logic                   batchHit
);

    shadowStateT state;
    fragmentT    slotFrag;
    fragmentT    workFrag;

    logic takeInput;
    logic moveInput;
    logic bypass;
    logic inAnyHit;
    logic searchDone;

    assign takeInput = addInput && !fifoFull;
    assign moveInput = (state == ShdwInit) && fifoFull;
    // No surface or shadowing off skips the search entirely
    assign bypass    = !shadowEnable || (slotFrag.surface == SurfNone);
    assign inAnyHit  = (state == ShdwAnyHit);

    // ------------------------------------------------------------------------
    // Search control
    // ------------------------------------------------------------------------
    assign queueClear = moveInput;
    assign stepClear  = moveInput;
    assign pushGlobal = moveInput && !bypass && (globalGroup.count != '0);
    assign pushLeaves = inAnyHit;
    assign step       = inAnyHit && !batchHit && batchLeft;
    // A group is popped only into an idle stepper
    assign pop        = inAnyHit && !batchHit && !batchLeft && !empty && (popGroup.count != '0);
    assign searchDone = inAnyHit && (batchHit || (!batchLeft && empty && travFinished));
    assign travRay    = workFrag.rayTag;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state       <= ShdwInit;
            fifoFull    <= 1'b0;
            valid       <= 1'b0;
            travStart   <= 1'b0;
            travRestart <= 1'b0;
        end else begin
            valid       <= 1'b0;
            travStart   <= 1'b0;
            travRestart <= 1'b0;
            if (takeInput) begin
                fifoFull <= 1'b1;
            end else if (moveInput) begin
                fifoFull <= 1'b0;
            end
            case (state)
                ShdwInit: begin
                    if (fifoFull) begin
                        if (bypass) begin
                            state <= ShdwDone;
                        end else begin
                            travStart <= 1'b1;
                            state     <= ShdwAnyHit;
                        end
                    end
                end
                ShdwAnyHit: begin
                    if (searchDone) begin
                        state <= ShdwDone;
                    end
                end
                ShdwDone: begin
                    // Hold here while the next stage is full
                    if (!outputFifoFull) begin
                        valid       <= 1'b1;
                        travRestart <= 1'b1;
                        state       <= ShdwInit;
                    end
                end
                default: begin
                    state <= ShdwInit;
                end
            endcase
        end
    end

    // Fragment payload and result register
    always_ff @(posedge clk) begin
        if (takeInput) begin
            slotFrag <= fragIn;
        end
        if (moveInput) begin
            workFrag <= slotFrag;
            if (bypass) begin
                result <= '{frag: slotFrag, inShadow: 1'b0};
            end
        end
        if (searchDone) begin
            result <= '{frag: workFrag, inShadow: batchHit};
        end
    end

endmodule

// ==== hdl/ShadowUnit.sv ====
// Shadow stage top level joining configuration, group queue, batch stepper and controller
`timescale 1ns/1ps

module ShadowUnit
    import BvhPkg::*, FragmentPkg::*;
(
    input  logic                      clk,
    input  logic                      resetn,
    input  logic                      addInput,
    input  fragmentT                  fragIn,
    output logic                      fifoFull,
    input  logic                      outputFifoFull,
    output logic                      valid,
    output shadowResultT              result,
    input  logic                      cfgWrite,
    input  logic [CfgAddrWidth-1:0]   cfgAddr,
    input  logic [CfgDataWidth-1:0]   cfgData,
    output logic                      travStart,
    output logic                      travRestart,
    output logic [RayTagWidth-1:0]    travRay,
    input  leafBundleT                leaves,
    input  logic                      travFinished,
    output logic [PrimIndexWidth-1:0] startPrimitive,
    output logic [PrimIndexWidth-1:0] endPrimitive,
    input  laneMaskT                  laneHits
);

    logic      shadowEnable;
    primGroupT globalGroup;
    logic      queueClear;
    logic      pushGlobal;
    logic      pushLeaves;
    logic      pop;
    logic      empty;
    primGroupT popGroup;
    logic      stepClear;
    logic      step;
    logic      batchLeft;
    logic      batchHit;

    ShadowConfig shadowConfig (
        .clk          (clk),
        .resetn       (resetn),
        .cfgWrite     (cfgWrite),
        .cfgAddr      (cfgAddr),
        .cfgData      (cfgData),
        .shadowEnable (shadowEnable),
        .globalGroup  (globalGroup)
    );

    PrimitiveGroupQueue groupQueue (
        .clk         (clk),
        .resetn      (resetn),
        .clear       (queueClear),
        .pushGlobal  (pushGlobal),
        .globalGroup (globalGroup),
        .pushLeaves  (pushLeaves),
        .leaves      (leaves),
        .pop         (pop),
        .popGroup    (popGroup),
        .empty       (empty)
    );

    // Each popped group is loaded straight into the stepper
    BatchStepper batchStepper (
        .clk            (clk),
        .resetn         (resetn),
        .clear          (stepClear),
        .load           (pop),
        .step           (step),
        .group          (popGroup),
        .laneHits       (laneHits),
        .startPrimitive (startPrimitive),
        .endPrimitive   (endPrimitive),
        .batchLeft      (batchLeft),
        .batchHit       (batchHit)
    );

    ShadowControl shadowControl (
        .clk            (clk),
        .resetn         (resetn),
        .addInput       (addInput),
        .fragIn         (fragIn),
        .fifoFull       (fifoFull),
        .outputFifoFull (outputFifoFull),
        .valid          (valid),
        .result         (result),
        .shadowEnable   (shadowEnable),
        .globalGroup    (globalGroup),
        .travStart      (travStart),
        .travRestart    (travRestart),
        .travRay        (travRay),
        .travFinished   (travFinished),
        .queueClear     (queueClear),
        .pushGlobal     (pushGlobal),
        .pushLeaves     (pushLeaves),
        .pop            (pop),
        .stepClear      (stepClear),
        .step           (step),
        .empty          (empty),
        .popGroup       (popGroup),
        .batchLeft      (batchLeft),
        .batchHit       (batchHit)
    );

endmodule

// ==== tests/ShadowUnit_chk.sv ====
// Protocol checker for the shadow stage output pulse, traversal restart and input slot
`timescale 1ns/1ps

module ShadowUnitChk (
    input logic clk,
    input logic resetn,
    input logic valid,
    input logic outputFifoFull,
    input logic travRestart,
    input logic fifoFull
);

    // Failed rules so far
    int failCount = 0;

    // Output pulse only after a cycle with room downstream
    validNeedsRoom: assert property (@(posedge clk) disable iff (!resetn)
        $rose(valid) |-> !$past(outputFifoFull)
    ) else begin
        failCount++;
        $error("valid rose after a cycle with outputFifoFull high");
    end

    restartWithValid: assert property (@(posedge clk) disable iff (!resetn)
        travRestart == valid
    ) else begin
        failCount++;
        $error("travRestart and valid differ");
    end

    // Input slot comes out of reset empty
    slotEmptyAfterReset: assert property (@(posedge clk) $rose(resetn) |-> !fifoFull)
        else begin
            failCount++;
            $error("fifoFull high after reset");
        end

endmodule

// ==== tests/ShadowUnitTb.sv ====
// Testbench for the shadow stage with traversal and ray-unit models and a reference check
`timescale 1ns/1ps

module ShadowUnitTb
    import BvhPkg::*, FragmentPkg::*;
();

    localparam int MaxFrags      = 64;
    localparam int MaxLeaves     = 12;
    localparam int HitsPerFrag   = 4;
    localparam int NoHit         = 4000;
    localparam int TotalFrags    = 39;
    localparam int CyclesPerFrag = 400;
    localparam int TimeoutCycles = TotalFrags * CyclesPerFrag;

    logic                      clk;
    logic                      resetn;
    logic                      addInput;
    fragmentT                  fragIn;
    logic                      fifoFull;
    logic                      outputFifoFull;
    logic                      valid;
    shadowResultT              result;
    logic                      cfgWrite;
    logic [CfgAddrWidth-1:0]   cfgAddr;
    logic [CfgDataWidth-1:0]   cfgData;
    logic                      travStart;
    logic                      travRestart;
    logic [RayTagWidth-1:0]    travRay;
    leafBundleT                leaves;
    logic                      travFinished;
    logic [PrimIndexWidth-1:0] startPrimitive;
    logic [PrimIndexWidth-1:0] endPrimitive;
    laneMaskT                  laneHits;

    // Per-fragment script: payload, leaf ranges in traversal order and hit indices
    fragmentT frags [MaxFrags];
    int       bundleCount [MaxFrags];
    int       leafStart [MaxFrags][MaxLeaves];
    int       leafCount [MaxFrags][MaxLeaves];
    int       hitIdx [MaxFrags][HitsPerFrag];
    logic     expShadow [MaxFrags];
    int       expLatency [MaxFrags];
    int       takeCycle [MaxFrags];
    string    testName [MaxFrags];

    int   expQueue [$];
    int   travQueue [$];
    int   nFrag = 0;
    int   checkedCount = 0;
    int   cycle = 0;
    int   activeFrag = 0;
    // Mirror of the configuration registers
    logic cfgEnable;
    int   cfgGlobalStart;
    int   cfgGlobalCount;

    ShadowUnit i_dut (.*);

    bind ShadowUnit ShadowUnitChk protocolChk (
        .clk            (clk),
        .resetn         (resetn),
        .valid          (valid),
        .outputFifoFull (outputFifoFull),
        .travRestart    (travRestart),
        .fifoFull       (fifoFull)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stopWithFailure(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "Simulation stopped at cycle %0d", cycle);
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TimeoutCycles) begin
            stopWithFailure($sformatf("Timeout with %0d results outstanding", expQueue.size()));
        end
        assert (i_dut.protocolChk.failCount == 0)
            else stopWithFailure("A protocol assertion on the DUT failed");
    end

    // ------------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------------
    function automatic logic refShadow(input int f);
        logic anyHit;
        int   h;
        anyHit = 1'b0;
        for (int k = 0; k < HitsPerFrag; k++) begin
            h = hitIdx[f][k];
            if (h >= cfgGlobalStart && h < cfgGlobalStart + cfgGlobalCount) begin
                anyHit = 1'b1;
            end
            for (int j = 0; j < 2 * bundleCount[f]; j++) begin
                if (h >= leafStart[f][j] && h < leafStart[f][j] + leafCount[f][j]) begin
                    anyHit = 1'b1;
                end
            end
        end
        return cfgEnable && (frags[f].surface != SurfNone) && anyHit;
    endfunction

    function automatic logic isHit(input int f, input int prim);
        for (int k = 0; k < HitsPerFrag; k++) begin
            if (hitIdx[f][k] == prim) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // True when first and last bound one scripted group of the fragment
    function automatic logic matchesGroup(input int f, input int first, input int last);
        if (cfgGlobalCount != 0 && first == cfgGlobalStart
                && last == cfgGlobalStart + cfgGlobalCount) begin
            return 1'b1;
        end
        for (int j = 0; j < 2 * bundleCount[f]; j++) begin
            if (leafCount[f][j] != 0 && first == leafStart[f][j]
                    && last == leafStart[f][j] + leafCount[f][j]) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    function automatic leafBundleT makeBundle(input int f, input int b);
        leafBundleT lb;
        for (int j = 0; j < 2; j++) begin
            lb.leaf[j].start = PrimIndexWidth'(leafStart[f][2 * b + j]);
            lb.leaf[j].count = PrimCountWidth'(leafCount[f][2 * b + j]);
        end
        return lb;
    endfunction

    // ------------------------------------------------------------------------
    // Traversal and ray-unit models
    // ------------------------------------------------------------------------
    initial begin : fabricModel
        logic                      startSeen;
        logic                      restartSeen;
        logic                      busy;
        int                        bundle;
        logic [PrimIndexWidth-1:0] lastEnd;
        leaves       = '0;
        travFinished = 1'b0;
        laneHits     = '0;
        busy         = 1'b0;
        bundle       = 0;
        lastEnd      = '0;
        forever begin
            @(posedge clk);
            startSeen   = travStart;
            restartSeen = travRestart;
            #1;
            if (restartSeen) begin
                busy         = 1'b0;
                travFinished = 1'b0;
            end else if (startSeen) begin
                assert (travQueue.size() != 0)
                    else stopWithFailure("travStart for a fragment that needs no search");
                activeFrag = travQueue.pop_front();
                assert (travRay == frags[activeFrag].rayTag)
                    else stopWithFailure($sformatf("error %s ray tag expected %h actual %h",
                        testName[activeFrag], frags[activeFrag].rayTag, travRay));
                busy   = 1'b1;
                bundle = 0;
            end else if (busy) begin
                bundle++;
            end
            // One bundle per cycle, then finished until restart
            if (busy && bundle < bundleCount[activeFrag]) begin
                leaves = makeBundle(activeFrag, bundle);
            end else begin
                leaves       = '0;
                travFinished = busy;
            end
            // A new group carries its real end, without padding
            if (endPrimitive != lastEnd && endPrimitive != '0) begin
                assert (matchesGroup(activeFrag, int'(startPrimitive), int'(endPrimitive)))
                    else stopWithFailure($sformatf(
                        "error %s endPrimitive %0d is no group end for start %0d",
                        testName[activeFrag], endPrimitive, startPrimitive));
            end
            lastEnd = endPrimitive;
            for (int i = 0; i < LaneCount; i++) begin
                laneHits[i] = isHit(activeFrag, int'(startPrimitive) + i);
            end
        end
    end

    // ------------------------------------------------------------------------
    // Result comparison
    // ------------------------------------------------------------------------
    initial begin : compareResults
        int           f;
        shadowResultT expected;
        forever begin
            @(posedge clk);
            if (valid) begin
                assert (expQueue.size() != 0)
                    else stopWithFailure("valid pulsed with no fragment outstanding");
                f = expQueue.pop_front();
                expected = '{frag: frags[f], inShadow: expShadow[f]};
                assert (result === expected)
                    else stopWithFailure($sformatf("error %s expected %h actual %h",
                        testName[f], expected, result));
                if (expLatency[f] != 0) begin
                    assert (cycle - takeCycle[f] == expLatency[f])
                        else stopWithFailure($sformatf("error %s latency expected %0d actual %0d",
                            testName[f], expLatency[f], cycle - takeCycle[f]));
                end
                checkedCount++;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------
    task automatic randomPayload(input int f);
        frags[f].pixelX  = 10'($urandom);
        frags[f].pixelY  = 10'($urandom);
        frags[f].color   = 24'($urandom);
        frags[f].surface = surfaceT'($urandom_range(0, 3));
        frags[f].rayTag  = 16'($urandom);
        bundleCount[f]   = 0;
        for (int k = 0; k < HitsPerFrag; k++) begin
            hitIdx[f][k] = NoHit;
        end
    endtask

    task automatic buildRandom(input int f);
        int pick;
        randomPayload(f);
        bundleCount[f] = $urandom_range(0, 6);
        for (int j = 0; j < 2 * bundleCount[f]; j++) begin
            leafStart[f][j] = $urandom_range(16, 2000);
            leafCount[f][j] = ($urandom_range(0, 3) == 0) ? 0 : $urandom_range(1, 24);
        end
        for (int k = 0; k < HitsPerFrag; k++) begin
            if (bundleCount[f] != 0 && $urandom_range(0, 2) == 0) begin
                pick = $urandom_range(0, 2 * bundleCount[f] - 1);
                // Lands in the real range or in its padding
                hitIdx[f][k] = leafStart[f][pick] + $urandom_range(0, 27);
            end else begin
                hitIdx[f][k] = $urandom_range(0, 2100);
            end
        end
    endtask

    // Hits only in the padding of two odd-sized leaves, optionally one real hit
    task automatic buildPadded(input int f, input logic realHit);
        int s;
        int c0;
        int c1;
        randomPayload(f);
        frags[f].surface = SurfSpecular;
        s  = $urandom_range(100, 1700);
        c0 = 4 * $urandom_range(0, 4) + $urandom_range(1, 3);
        c1 = 4 * $urandom_range(0, 4) + $urandom_range(1, 3);
        bundleCount[f]  = 1;
        leafStart[f][0] = s;
        leafCount[f][0] = c0;
        leafStart[f][1] = s + 200;
        leafCount[f][1] = c1;
        hitIdx[f][0] = s + c0;
        hitIdx[f][1] = s + ((c0 + 3) / 4) * 4 - 1;
        hitIdx[f][2] = s + 200 + c1;
        hitIdx[f][3] = realHit ? s + c0 - 1 : s + 200 + ((c1 + 3) / 4) * 4 - 1;
    endtask

    task automatic launch(input string name, input int latency);
        int f;
        f = nFrag;
        nFrag++;
        testName[f]   = name;
        expLatency[f] = latency;
        expShadow[f]  = refShadow(f);
        if (cfgEnable && frags[f].surface != SurfNone) begin
            travQueue.push_back(f);
        end
        expQueue.push_back(f);
        addInput = 1'b1;
        fragIn   = frags[f];
        do begin
            @(posedge clk);
        end while (fifoFull);
        takeCycle[f] = cycle;
        #1;
        addInput = 1'b0;
    endtask

    task automatic writeConfig(input logic [CfgAddrWidth-1:0] addr, input int data);
        cfgWrite = 1'b1;
        cfgAddr  = addr;
        cfgData  = CfgDataWidth'(data);
        @(posedge clk);
        #1;
        cfgWrite = 1'b0;
    endtask

    task automatic waitIdle();
        while (expQueue.size() != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    initial begin
        void'($urandom(99));
        resetn         = 1'b0;
        addInput       = 1'b0;
        fragIn         = '0;
        outputFifoFull = 1'b0;
        cfgWrite       = 1'b0;
        cfgAddr        = '0;
        cfgData        = '0;
        cfgEnable      = 1'b1;
        cfgGlobalStart = 0;
        cfgGlobalCount = 0;
        repeat (4) @(posedge clk);
        #1;
        resetn = 1'b1;

        for (int i = 0; i < 20; i++) begin
            buildRandom(nFrag);
            launch("random", 0);
        end
        for (int i = 0; i < 4; i++) begin
            buildPadded(nFrag, i == 3);
            launch("padded lanes", 0);
        end

        // Bypass on a missing surface, then with shadowing switched off
        waitIdle();
        for (int i = 0; i < 3; i++) begin
            buildRandom(nFrag);
            frags[nFrag].surface = SurfNone;
            launch("no surface", (i == 0) ? 3 : 0);
        end
        waitIdle();
        writeConfig(CfgAddrEnable, 0);
        cfgEnable = 1'b0;
        for (int i = 0; i < 4; i++) begin
            buildRandom(nFrag);
            launch("shadow disabled", (i == 0) ? 3 : 0);
        end
        waitIdle();
        writeConfig(CfgAddrEnable, 1);
        cfgEnable = 1'b1;

        // Consumer full
        outputFifoFull = 1'b1;
        for (int i = 0; i < 2; i++) begin
            buildRandom(nFrag);
            launch("back pressure", 0);
        end
        repeat (60) begin
            @(posedge clk);
            assert (!valid) else stopWithFailure("valid pulsed while the consumer was full");
        end
        #1;
        outputFifoFull = 1'b0;

        waitIdle();
        writeConfig(CfgAddrGlobalStart, 1200);
        writeConfig(CfgAddrGlobalCount, 10);
        cfgGlobalStart = 1200;
        cfgGlobalCount = 10;
        randomPayload(nFrag);
        frags[nFrag].surface = SurfDiffuse;
        hitIdx[nFrag][0] = 1205;
        launch("global group hit", 0);
        randomPayload(nFrag);
        frags[nFrag].surface = SurfLight;
        hitIdx[nFrag][0] = 1210;
        launch("global group padding", 0);
        for (int i = 0; i < 4; i++) begin
            buildRandom(nFrag);
            hitIdx[nFrag][1] = $urandom_range(1190, 1220);
            launch("global group random", 0);
        end
        waitIdle();
        writeConfig(CfgAddrGlobalCount, 0);
        cfgGlobalCount = 0;

        if (checkedCount == TotalFrags && nFrag == TotalFrags) begin
            $display("** PASS **");
            $finish;
        end else begin
            stopWithFailure($sformatf("Checked %0d of %0d results", checkedCount, TotalFrags));
        end
    end

endmodule

// ==== tb.f ====
hdl/BvhPkg.sv
hdl/FragmentPkg.sv
hdl/ShadowConfig.sv
hdl/PrimitiveGroupQueue.sv
hdl/BatchStepper.sv
hdl/ShadowControl.sv
hdl/ShadowUnit.sv
tests/ShadowUnit_chk.sv
tests/ShadowUnitTb.sv

// ==== Bender.yml ====
package:
  name: shadow_unit

sources:
  # Design
  - files:
      - hdl/BvhPkg.sv
      - hdl/FragmentPkg.sv
      - hdl/ShadowConfig.sv
      - hdl/PrimitiveGroupQueue.sv
      - hdl/BatchStepper.sv
      - hdl/ShadowControl.sv
      - hdl/ShadowUnit.sv

  # Verification
  - target: test
    files:
      - tests/ShadowUnit_chk.sv
      - tests/ShadowUnitTb.sv
